// File: design/cache_types_pkg.sv
package cache_types_pkg;

    // Data word and byte address widths
    localparam int WORD_W = 32;
    localparam int ADDR_W = 32;

    // A cache line is eight words, one per memory bank
    localparam int LINE_WORDS = 8;
    localparam int LINE_W = 256;

    // Address layout of a line access
    // Bits [4:0] select a byte inside the line and are ignored by memory
    localparam int OFFSET_BITS = 5;

    // Bits [10:5] select one of the lines held by the banks.
    // Anything above bit 10 is dropped, so such addresses alias
    localparam int INDEX_BITS = 6;

    // Words in each bank, which equals the number of lines in memory
    localparam int BANK_DEPTH = 64;

    // Cycles from the first cycle an access is seen to mem_resp
    localparam int MEM_LATENCY = 4;

endpackage

// File: design/word_bank.sv
`timescale 1ns/1ps

module word_bank (
    input  logic                                   clk,
    input  logic                                   en,
    input  logic                                   we,
    input  logic [cache_types_pkg::INDEX_BITS-1:0] index,
    input  logic [cache_types_pkg::WORD_W-1:0]     wdata,
    output logic [cache_types_pkg::WORD_W-1:0]     rdata
);

    logic [cache_types_pkg::WORD_W-1:0] mem [cache_types_pkg::BANK_DEPTH];

    // Rdata holds the last word read, a write leaves it alone
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[index] <= wdata;
            end else begin
                rdata <= mem[index];
            end
        end
    end

endmodule

// File: design/line_mem_ctrl.sv
`timescale 1ns/1ps

module line_mem_ctrl (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [cache_types_pkg::ADDR_W-1:0]     mem_addr,
    input  logic                                   mem_read,
    input  logic                                   mem_write,
    output logic                                   mem_resp,
    output logic                                   bank_en,
    output logic                                   bank_we,
    output logic [cache_types_pkg::INDEX_BITS-1:0] bank_index
);

    logic busy;
    logic resp_q; // High in the cycle after mem_resp
    logic start;
    logic [$clog2(cache_types_pkg::MEM_LATENCY + 1)-1:0] lat_cnt;

    // A request still held right after its response belongs to the old access
    assign start = (mem_read | mem_write) & ~busy & ~resp_q;

    // All banks are touched in the first cycle, the rest is waiting out the latency
    assign bank_en    = start;
    assign bank_we    = start & mem_write;
    assign bank_index = mem_addr[cache_types_pkg::OFFSET_BITS +: cache_types_pkg::INDEX_BITS];

    assign mem_resp = busy && (lat_cnt == $bits(lat_cnt)'(cache_types_pkg::MEM_LATENCY));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            lat_cnt <= '0;
            resp_q  <= 1'b0;
        end else begin
            resp_q <= mem_resp;
            if (start) begin
                busy    <= 1'b1;
                lat_cnt <= 1'b1; // The start cycle counts as the first one
            end else if (mem_resp) begin
                busy    <= 1'b0;
                lat_cnt <= '0;
            end else if (busy) begin
                lat_cnt <= lat_cnt + 1'b1;
            end
        end
    end

    resp_single_pulse: assert property (@(posedge clk) disable iff (rst)
        mem_resp |=> !mem_resp);

    read_write_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write));

endmodule

// File: design/cache_arbiter.sv
`timescale 1ns/1ps

module cache_arbiter (
    input  logic                               clk,
    input  logic                               rst,

    input  logic [cache_types_pkg::ADDR_W-1:0] icache_addr,
    input  logic                               icache_read,
    output logic [cache_types_pkg::LINE_W-1:0] icache_data,
    output logic                               icache_resp,

    input  logic [cache_types_pkg::ADDR_W-1:0] dcache_addr,
    input  logic [cache_types_pkg::LINE_W-1:0] dcache_data_w,
    input  logic                               dcache_read,
    input  logic                               dcache_write,
    output logic [cache_types_pkg::LINE_W-1:0] dcache_data_r,
    output logic                               dcache_resp,

    input  logic [cache_types_pkg::LINE_W-1:0] mem_data_r,
    input  logic                               mem_resp,
    output logic [cache_types_pkg::ADDR_W-1:0] mem_addr,
    output logic [cache_types_pkg::LINE_W-1:0] mem_data_w,
    output logic                               mem_read,
    output logic                               mem_write
);

    typedef enum logic [1:0] {
        st_idle,
        st_icache,
        st_dcache
    } state_t;

    state_t state;
    state_t next_state;

    logic dcache_req;

    assign dcache_req = dcache_read | dcache_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // Icache wins a tie from idle. After each response the other cache is served
    // first if it is waiting, which keeps either side from starving
    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (icache_read) begin
                    next_state = st_icache;
                end else if (dcache_req) begin
                    next_state = st_dcache;
                end
            end
            st_icache: begin
                if (mem_resp) begin
                    next_state = dcache_req ? st_dcache : st_idle;
                end
            end
            st_dcache: begin
                if (mem_resp) begin
                    next_state = icache_read ? st_icache : st_idle;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    // Only the granted cache sees memory, everything else stays at zero
    always_comb begin
        icache_data   = '0;
        icache_resp   = 1'b0;
        dcache_data_r = '0;
        dcache_resp   = 1'b0;
        mem_addr      = '0;
        mem_data_w    = '0;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        case (state)
            st_icache: begin
                icache_data = mem_data_r;
                icache_resp = mem_resp;
                mem_addr    = icache_addr;
                mem_read    = icache_read; // Instruction side is read only
            end
            st_dcache: begin
                dcache_data_r = mem_data_r;
                dcache_resp   = mem_resp;
                mem_addr      = dcache_addr;
                mem_data_w    = dcache_data_w;
                mem_read      = dcache_read;
                mem_write     = dcache_write;
            end
            default: ;
        endcase
    end

    resp_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(icache_resp && dcache_resp));

    icache_no_write: assert property (@(posedge clk) disable iff (rst)
        (state == st_icache) |-> !mem_write);

endmodule

// File: design/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem (
    input  logic                               clk,
    input  logic                               rst,

    input  logic [cache_types_pkg::ADDR_W-1:0] icache_addr,
    input  logic                               icache_read,
    output logic [cache_types_pkg::LINE_W-1:0] icache_data,
    output logic                               icache_resp,

    input  logic [cache_types_pkg::ADDR_W-1:0] dcache_addr,
    input  logic [cache_types_pkg::LINE_W-1:0] dcache_data_w,
    input  logic                               dcache_read,
    input  logic                               dcache_write,
    output logic [cache_types_pkg::LINE_W-1:0] dcache_data_r,
    output logic                               dcache_resp
);

    logic [cache_types_pkg::ADDR_W-1:0]     mem_addr;
    logic [cache_types_pkg::LINE_W-1:0]     mem_data_w;
    logic [cache_types_pkg::LINE_W-1:0]     mem_data_r;
    logic                                   mem_read;
    logic                                   mem_write;
    logic                                   mem_resp;
    logic                                   bank_en;
    logic                                   bank_we;
    logic [cache_types_pkg::INDEX_BITS-1:0] bank_index;

    cache_arbiter arbiter_inst (
        .clk           (clk),
        .rst           (rst),
        .icache_addr   (icache_addr),
        .icache_read   (icache_read),
        .icache_data   (icache_data),
        .icache_resp   (icache_resp),
        .dcache_addr   (dcache_addr),
        .dcache_data_w (dcache_data_w),
        .dcache_read   (dcache_read),
        .dcache_write  (dcache_write),
        .dcache_data_r (dcache_data_r),
        .dcache_resp   (dcache_resp),
        .mem_data_r    (mem_data_r),
        .mem_resp      (mem_resp),
        .mem_addr      (mem_addr),
        .mem_data_w    (mem_data_w),
        .mem_read      (mem_read),
        .mem_write     (mem_write)
    );

    line_mem_ctrl ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .mem_addr   (mem_addr),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_resp   (mem_resp),
        .bank_en    (bank_en),
        .bank_we    (bank_we),
        .bank_index (bank_index)
    );

    // Word 0 of the line sits in the low bits and lives in bank 0
    for (genvar k = 0; k < cache_types_pkg::LINE_WORDS; k++) begin : g_bank
        word_bank bank_inst (
            .clk   (clk),
            .en    (bank_en),
            .we    (bank_we),
            .index (bank_index),
            .wdata (mem_data_w[k*cache_types_pkg::WORD_W +: cache_types_pkg::WORD_W]),
            .rdata (mem_data_r[k*cache_types_pkg::WORD_W +: cache_types_pkg::WORD_W])
        );
    end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 40 ns period, starting low
    initial begin
        clk = 1'b0;
    end

    always begin
        #20 clk = ~clk;
    end

endmodule

// File: tests/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int RESET_CYCLES   = 8;

    logic                               clk;
    logic                               rst;
    logic [cache_types_pkg::ADDR_W-1:0] icache_addr;
    logic                               icache_read;
    logic [cache_types_pkg::LINE_W-1:0] icache_data;
    logic                               icache_resp;
    logic [cache_types_pkg::ADDR_W-1:0] dcache_addr;
    logic [cache_types_pkg::LINE_W-1:0] dcache_data_w;
    logic                               dcache_read;
    logic                               dcache_write;
    logic [cache_types_pkg::LINE_W-1:0] dcache_data_r;
    logic                               dcache_resp;

    // Expected memory contents, one entry per line index
    logic [cache_types_pkg::LINE_W-1:0] ref_mem [cache_types_pkg::BANK_DEPTH];
    bit                                 written [cache_types_pkg::BANK_DEPTH];

    logic [31:0] rng_state;
    int          error_count;
    int          timeout_count;

    tb_clock clock_inst (
        .clk (clk)
    );

    mem_subsystem mem_subsystem_inst (
        .clk           (clk),
        .rst           (rst),
        .icache_addr   (icache_addr),
        .icache_read   (icache_read),
        .icache_data   (icache_data),
        .icache_resp   (icache_resp),
        .dcache_addr   (dcache_addr),
        .dcache_data_w (dcache_data_w),
        .dcache_read   (dcache_read),
        .dcache_write  (dcache_write),
        .dcache_data_r (dcache_data_r),
        .dcache_resp   (dcache_resp)
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [cache_types_pkg::LINE_W-1:0] random_line();
        logic [cache_types_pkg::LINE_W-1:0] data;
        for (int w = 0; w < cache_types_pkg::LINE_WORDS; w++) begin
            data[w*cache_types_pkg::WORD_W +: cache_types_pkg::WORD_W] = next_random();
        end
        return data;
    endfunction

    // Bits just above the byte offset pick the line, higher bits are dropped
    function automatic int line_index(input logic [cache_types_pkg::ADDR_W-1:0] addr);
        return int'(addr[cache_types_pkg::OFFSET_BITS +: cache_types_pkg::INDEX_BITS]);
    endfunction

    task automatic check_value(input string name,
                               input logic [cache_types_pkg::LINE_W-1:0] actual,
                               input logic [cache_types_pkg::LINE_W-1:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    // Returns on the falling edge where resp is high, or after the timeout
    task automatic wait_resp(input bit icache_side, input string what, output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            seen = icache_side ? icache_resp : dcache_resp;
        end
        if (!seen) begin
            timeout_count++;
            $display("Timeout at %0t: %s got no response within %0d cycles",
                     $time, what, TIMEOUT_CYCLES);
        end
    endtask

    task automatic dcache_write_line(input logic [cache_types_pkg::ADDR_W-1:0] addr,
                                     input logic [cache_types_pkg::LINE_W-1:0] data);
        bit seen;
        @(negedge clk);
        dcache_addr   = addr;
        dcache_data_w = data;
        dcache_write  = 1'b1;
        wait_resp(1'b0, "dcache write", seen);
        dcache_write = 1'b0;
        ref_mem[line_index(addr)] = data; // Last write wins for aliasing addresses
        written[line_index(addr)] = 1'b1;
    endtask

    task automatic dcache_read_check(input logic [cache_types_pkg::ADDR_W-1:0] addr);
        bit seen;
        @(negedge clk);
        dcache_addr = addr;
        dcache_read = 1'b1;
        wait_resp(1'b0, "dcache read", seen);
        if (seen) begin
            check_value("dcache_data_r", dcache_data_r, ref_mem[line_index(addr)]);
        end
        dcache_read = 1'b0;
    endtask

    task automatic icache_read_check(input logic [cache_types_pkg::ADDR_W-1:0] addr);
        bit seen;
        @(negedge clk);
        icache_addr = addr;
        icache_read = 1'b1;
        wait_resp(1'b1, "icache read", seen);
        if (seen) begin
            check_value("icache_data", icache_data, ref_mem[line_index(addr)]);
        end
        icache_read = 1'b0;
    endtask

    task automatic test_idle_after_reset();
        repeat (6) begin
            @(negedge clk);
            check_value("icache_resp", icache_resp, 1'b0);
            check_value("dcache_resp", dcache_resp, 1'b0);
        end
    endtask

    task automatic test_write_then_read();
        logic [cache_types_pkg::ADDR_W-1:0] addr;
        addr = next_random();
        dcache_write_line(addr, random_line());
        dcache_read_check(addr);
    endtask

    task automatic test_icache_reads_dcache_write();
        logic [cache_types_pkg::ADDR_W-1:0] addr;
        addr = next_random();
        dcache_write_line(addr, random_line());
        icache_read_check(addr);
        dcache_read_check(addr); // The icache read must leave the line untouched
    endtask

    task automatic test_simultaneous_requests();
        logic [cache_types_pkg::ADDR_W-1:0] addr_i;
        logic [cache_types_pkg::ADDR_W-1:0] addr_d;
        bit icache_done;
        bit dcache_done;
        int cycles;
        int icache_at;
        int dcache_at;
        addr_i = next_random();
        addr_d = addr_i + 32'd32; // Next line, so a different index
        dcache_write_line(addr_i, random_line());
        dcache_write_line(addr_d, random_line());
        icache_done = 1'b0;
        dcache_done = 1'b0;
        cycles = 0;
        icache_at = 0;
        dcache_at = 0;
        @(negedge clk);
        icache_addr = addr_i;
        icache_read = 1'b1;
        dcache_addr = addr_d;
        dcache_read = 1'b1;
        while (!(icache_done && dcache_done) && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (icache_resp && !icache_done) begin
                icache_done = 1'b1;
                icache_at = cycles;
                check_value("icache_data", icache_data, ref_mem[line_index(addr_i)]);
                icache_read = 1'b0;
            end
            if (dcache_resp && !dcache_done) begin
                dcache_done = 1'b1;
                dcache_at = cycles;
                check_value("dcache_data_r", dcache_data_r, ref_mem[line_index(addr_d)]);
                dcache_read = 1'b0;
            end
        end
        icache_read = 1'b0;
        dcache_read = 1'b0;
        if (!(icache_done && dcache_done)) begin
            timeout_count++;
            $display("Timeout at %0t: simultaneous requests did not both complete", $time);
        end else begin
            check_value("icache_resp_before_dcache_resp", icache_at < dcache_at, 1'b1);
        end
    endtask

    task automatic test_alternation();
        logic [cache_types_pkg::ADDR_W-1:0] addr_i;
        logic [cache_types_pkg::ADDR_W-1:0] addr_d;
        bit seen;
        bit expect_icache;
        int cycles;
        addr_i = next_random();
        addr_d = addr_i + 32'd64;
        dcache_write_line(addr_i, random_line());
        dcache_write_line(addr_d, random_line());
        @(negedge clk);
        icache_addr = addr_i;
        icache_read = 1'b1;
        dcache_addr = addr_d;
        dcache_read = 1'b1;
        // Both stay held, so every response starts the next access at once
        for (int n = 0; n < 10; n++) begin
            seen = 1'b0;
            cycles = 0;
            while (!seen && cycles < TIMEOUT_CYCLES) begin
                @(negedge clk);
                cycles++;
                seen = icache_resp | dcache_resp;
            end
            if (!seen) begin
                timeout_count++;
                $display("Timeout at %0t: held requests stopped getting responses", $time);
                break;
            end
            expect_icache = (n % 2 == 0);
            check_value("icache_resp", icache_resp, expect_icache);
            check_value("dcache_resp", dcache_resp, !expect_icache);
            if (icache_resp) begin
                check_value("icache_data", icache_data, ref_mem[line_index(addr_i)]);
            end
            if (dcache_resp) begin
                check_value("dcache_data_r", dcache_data_r, ref_mem[line_index(addr_d)]);
            end
        end
        icache_read = 1'b0;
        dcache_read = 1'b0;
    endtask

    task automatic test_random_traffic();
        logic [31:0] r;
        logic [cache_types_pkg::ADDR_W-1:0] addr;
        for (int i = 0; i < 40; i++) begin
            r = next_random();
            addr = next_random();
            // Eight indices with random upper bits, so aliasing is common
            addr[cache_types_pkg::OFFSET_BITS +: cache_types_pkg::INDEX_BITS] =
                r[8 +: cache_types_pkg::INDEX_BITS] & 'h7;
            // The low LCG bits repeat with a short period, the top bit picks the access
            if (r[31] || !written[line_index(addr)]) begin
                dcache_write_line(addr, random_line());
            end else begin
                dcache_read_check(addr);
            end
        end
    endtask

    initial begin
        rng_state     = 32'h599c_6d7c;
        error_count   = 0;
        timeout_count = 0;
        rst           = 1'b1;
        icache_addr   = '0;
        icache_read   = 1'b0;
        dcache_addr   = '0;
        dcache_data_w = '0;
        dcache_read   = 1'b0;
        dcache_write  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_idle_after_reset();
        test_write_then_read();
        test_icache_reads_dcache_write();
        test_simultaneous_requests();
        test_alternation();
        test_random_traffic();

        $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
design/cache_types_pkg.sv
design/word_bank.sv
design/line_mem_ctrl.sv
design/cache_arbiter.sv
design/mem_subsystem.sv
tests/tb_clock.sv
tests/mem_subsystem_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := mem_subsystem_tb
RTL_TOP    := mem_subsystem
FILELIST   := vlog.f
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
